//--- hw/rv_isa_pkg.sv
// rv32i isa encodings
// major opcodes, instruction types, alu operations and funct3 values
package rv_isa_pkg;

    // major opcodes, load/store/system only recognized, never executed
    typedef enum logic [6:0] {
        OPC_OP     = 7'b0110011,
        OPC_OP_IMM = 7'b0010011,
        OPC_LUI    = 7'b0110111,
        OPC_AUIPC  = 7'b0010111,
        OPC_JAL    = 7'b1101111,
        OPC_JALR   = 7'b1100111,
        OPC_BRANCH = 7'b1100011,
        OPC_LOAD   = 7'b0000011,
        OPC_STORE  = 7'b0100011,
        OPC_SYSTEM = 7'b1110011
    } opcode_e;

    typedef enum logic [2:0] {
        TYPE_R,
        TYPE_I,
        TYPE_S,
        TYPE_B,
        TYPE_U,
        TYPE_J,
        TYPE_N  // no operands, retires as a no-op
    } inst_type_e;

    typedef enum logic [3:0] {
        ALU_ADD,
        ALU_SUB,
        ALU_SLL,
        ALU_SLT,
        ALU_SLTU,
        ALU_XOR,
        ALU_SRL,
        ALU_SRA,
        ALU_OR,
        ALU_AND
    } alu_op_e;

    // funct3 for OP / OP_IMM
    localparam logic [2:0] F3_ADD_SUB = 3'b000;
    localparam logic [2:0] F3_SLL     = 3'b001;
    localparam logic [2:0] F3_SLT     = 3'b010;
    localparam logic [2:0] F3_SLTU    = 3'b011;
    localparam logic [2:0] F3_XOR     = 3'b100;
    localparam logic [2:0] F3_SR      = 3'b101;  // srl or sra by funct7[5]
    localparam logic [2:0] F3_OR      = 3'b110;
    localparam logic [2:0] F3_AND     = 3'b111;

    // branch conditions
    localparam logic [2:0] F3_BEQ  = 3'b000;
    localparam logic [2:0] F3_BNE  = 3'b001;
    localparam logic [2:0] F3_BLT  = 3'b100;
    localparam logic [2:0] F3_BGE  = 3'b101;
    localparam logic [2:0] F3_BLTU = 3'b110;
    localparam logic [2:0] F3_BGEU = 3'b111;

endpackage

//--- hw/core_pkg.sv
// core datapath types
// word types and the records passed between fetch, decode and execute
package core_pkg;

    localparam int XLEN = 32;

    typedef logic [XLEN-1:0] xlen_t;
    typedef logic [4:0]      reg_addr_t;

    // fetch -> decode, 65 bits
    typedef struct packed {
        logic  valid;
        xlen_t pc;
        xlen_t inst;
    } fetch_pkt_t;

    typedef struct packed {
        xlen_t                  pc;
        rv_isa_pkg::inst_type_e inst_type;
        rv_isa_pkg::opcode_e    opcode;
        logic [2:0]             funct3;
        reg_addr_t              rs1;
        reg_addr_t              rs2;
        reg_addr_t              rd;
        xlen_t                  imm;
        rv_isa_pkg::alu_op_e    alu_op;
        logic                   valid;
    } decoded_t;

    // retirement record, 103 bits
    typedef struct packed {
        logic      valid;
        xlen_t     pc;
        xlen_t     next_pc;
        logic      rd_we;
        reg_addr_t rd;
        xlen_t     rd_data;
    } commit_t;

    typedef struct packed {
        xlen_t next_pc;
    } redirect_t;

endpackage

//--- hw/fetch_unit.sv
// instruction fetch
// pc register and the two-cycle idle/wait fetch sequence
`timescale 1ns/10ps

module fetch_unit #(
    parameter core_pkg::xlen_t RESET_PC = 32'h8000_0000
) (
    input  logic                 clk,
    input  logic                 reset,
    input  core_pkg::redirect_t  redirect,
    output core_pkg::xlen_t      imem_addr,
    input  core_pkg::xlen_t      imem_rdata,
    output core_pkg::fetch_pkt_t fetch
);
    import core_pkg::*;

    typedef enum logic {
        ST_IDLE,  // address out to memory
        ST_WAIT   // word back, instruction executes
    } fetch_state_e;

    fetch_state_e state;
    fetch_state_e state_next;
    xlen_t        pc;

    always_comb begin
        case (state)
            ST_IDLE: state_next = ST_WAIT;
            ST_WAIT: state_next = ST_IDLE;
            default: state_next = ST_IDLE;
        endcase
    end

    always_ff @(posedge clk) begin
        if (reset) begin
            state <= ST_IDLE;
        end else begin
            state <= state_next;
        end
    end

    // pc moves on only once the instruction has retired
    always_ff @(posedge clk) begin
        if (reset) begin
            pc <= RESET_PC;
        end else if (state == ST_WAIT) begin
            pc <= redirect.next_pc;
        end
    end

    assign imem_addr = pc;  // held across idle and wait

    always_comb begin
        fetch.valid = (state == ST_WAIT);
        fetch.pc    = pc;
        fetch.inst  = imem_rdata;
    end

endmodule

//--- hw/decode_unit.sv
// instruction decode
// field slicing, type classification, immediate build and alu op select
`timescale 1ns/10ps

module decode_unit (
    input  core_pkg::fetch_pkt_t fetch,
    output core_pkg::decoded_t   dec
);
    import rv_isa_pkg::*;
    import core_pkg::*;

    xlen_t      inst;
    opcode_e    opcode;
    logic [2:0] funct3;
    logic [6:0] funct7;
    inst_type_e inst_type;
    xlen_t      imm;
    alu_op_e    alu_op;

    assign inst   = fetch.inst;
    assign opcode = opcode_e'(inst[6:0]);
    assign funct3 = inst[14:12];
    assign funct7 = inst[31:25];

    always_comb begin
        case (opcode)
            OPC_OP:                            inst_type = TYPE_R;
            OPC_OP_IMM, OPC_JALR:              inst_type = TYPE_I;
            OPC_BRANCH:                        inst_type = TYPE_B;
            OPC_LUI, OPC_AUIPC:                inst_type = TYPE_U;
            OPC_JAL:                           inst_type = TYPE_J;
            OPC_LOAD, OPC_STORE, OPC_SYSTEM:   inst_type = TYPE_N;  // not supported here
            default:                           inst_type = TYPE_N;
        endcase
    end

    // sign-extended immediates
    always_comb begin
        case (inst_type)
            TYPE_I:  imm = {{20{inst[31]}}, inst[31:20]};
            TYPE_S:  imm = {{20{inst[31]}}, inst[31:25], inst[11:7]};
            TYPE_B:  imm = {{20{inst[31]}}, inst[7], inst[30:25], inst[11:8], 1'b0};
            TYPE_U:  imm = {inst[31:12], 12'h000};
            TYPE_J:  imm = {{12{inst[31]}}, inst[19:12], inst[20], inst[30:21], 1'b0};
            default: imm = '0;
        endcase
    end

    // everything outside OP / OP_IMM just needs an adder
    always_comb begin
        alu_op = ALU_ADD;
        if (opcode == OPC_OP || opcode == OPC_OP_IMM) begin
            case (funct3)
                F3_ADD_SUB: begin
                    if (inst_type == TYPE_R && funct7[5]) begin
                        alu_op = ALU_SUB;  // no subi
                    end
                end
                F3_SLL:  alu_op = ALU_SLL;
                F3_SLT:  alu_op = ALU_SLT;
                F3_SLTU: alu_op = ALU_SLTU;
                F3_XOR:  alu_op = ALU_XOR;
                F3_SR:   alu_op = funct7[5] ? ALU_SRA : ALU_SRL;
                F3_OR:   alu_op = ALU_OR;
                F3_AND:  alu_op = ALU_AND;
                default: alu_op = ALU_ADD;
            endcase
        end
    end

    always_comb begin
        dec.pc        = fetch.pc;
        dec.inst_type = inst_type;
        dec.opcode    = opcode;
        dec.funct3    = funct3;
        dec.rs1       = inst[19:15];
        dec.rs2       = inst[24:20];
        dec.rd        = inst[11:7];
        dec.imm       = imm;
        dec.alu_op    = alu_op;
        dec.valid     = fetch.valid;
    end

endmodule

//--- hw/reg_file.sv
// general register file
// 32 words, two combinational reads and one synchronous write
`timescale 1ns/10ps

module reg_file (
    input  logic                clk,
    input  logic                reset,
    input  logic                we,
    input  core_pkg::reg_addr_t waddr,
    input  core_pkg::xlen_t     wdata,
    input  core_pkg::reg_addr_t raddr1,
    input  core_pkg::reg_addr_t raddr2,
    output core_pkg::xlen_t     rdata1,
    output core_pkg::xlen_t     rdata2
);
    import core_pkg::*;

    xlen_t regs [32];

    // x0 stays zero since execute never writes rd 0
    always_ff @(posedge clk) begin
        if (reset) begin
            for (int i = 0; i < 32; i++) begin
                regs[i] <= '0;
            end
        end else if (we) begin
            regs[waddr] <= wdata;
        end
    end

    assign rdata1 = regs[raddr1];
    assign rdata2 = regs[raddr2];

endmodule

//--- hw/exec_unit.sv
// execute stage
// alu, branch compare, next pc and writeback select
`timescale 1ns/10ps

module exec_unit (
    input  core_pkg::decoded_t  dec,
    input  core_pkg::xlen_t     rdata1,
    input  core_pkg::xlen_t     rdata2,
    output core_pkg::commit_t   commit,
    output core_pkg::redirect_t redirect
);
    import rv_isa_pkg::*;
    import core_pkg::*;

    xlen_t      alu_a;
    xlen_t      alu_b;
    xlen_t      alu_result;
    logic [4:0] shamt;
    logic       taken;
    xlen_t      pc_plus4;
    xlen_t      next_pc;
    xlen_t      wb_data;
    logic       wb_en;

    // operand select by instruction type
    always_comb begin
        case (dec.inst_type)
            TYPE_R: begin
                alu_a = rdata1;
                alu_b = rdata2;
            end
            TYPE_I: begin  // op_imm and jalr
                alu_a = rdata1;
                alu_b = dec.imm;
            end
            TYPE_U: begin
                alu_a = (dec.opcode == OPC_LUI) ? '0 : dec.pc;
                alu_b = dec.imm;
            end
            TYPE_J, TYPE_B: begin
                alu_a = dec.pc;
                alu_b = dec.imm;
            end
            default: begin
                alu_a = rdata1;
                alu_b = rdata2;
            end
        endcase
    end

    assign shamt = alu_b[4:0];

    always_comb begin
        case (dec.alu_op)
            ALU_ADD:  alu_result = alu_a + alu_b;
            ALU_SUB:  alu_result = alu_a - alu_b;
            ALU_SLL:  alu_result = alu_a << shamt;
            ALU_SLT:  alu_result = {{(XLEN-1){1'b0}}, $signed(alu_a) < $signed(alu_b)};
            ALU_SLTU: alu_result = {{(XLEN-1){1'b0}}, alu_a < alu_b};
            ALU_XOR:  alu_result = alu_a ^ alu_b;
            ALU_SRL:  alu_result = alu_a >> shamt;
            ALU_SRA:  alu_result = xlen_t'($signed(alu_a) >>> shamt);
            ALU_OR:   alu_result = alu_a | alu_b;
            ALU_AND:  alu_result = alu_a & alu_b;
            default:  alu_result = alu_a + alu_b;
        endcase
    end

    // branch compare uses the registers, the alu forms the target
    always_comb begin
        case (dec.funct3)
            F3_BEQ:  taken = (rdata1 == rdata2);
            F3_BNE:  taken = (rdata1 != rdata2);
            F3_BLT:  taken = ($signed(rdata1) < $signed(rdata2));
            F3_BGE:  taken = ($signed(rdata1) >= $signed(rdata2));
            F3_BLTU: taken = (rdata1 < rdata2);
            F3_BGEU: taken = (rdata1 >= rdata2);
            default: taken = 1'b0;
        endcase
    end

    assign pc_plus4 = dec.pc + 32'd4;

    always_comb begin
        next_pc = pc_plus4;
        wb_data = alu_result;
        wb_en   = 1'b0;
        case (dec.opcode)
            OPC_OP, OPC_OP_IMM, OPC_LUI, OPC_AUIPC: wb_en = 1'b1;
            OPC_JAL: begin
                next_pc = alu_result;
                wb_data = pc_plus4;  // link
                wb_en   = 1'b1;
            end
            OPC_JALR: begin
                next_pc = {alu_result[XLEN-1:1], 1'b0};
                wb_data = pc_plus4;
                wb_en   = 1'b1;
            end
            OPC_BRANCH: if (taken) next_pc = alu_result;
            default: ;  // dropped opcodes fall through to pc+4
        endcase
    end

    always_comb begin
        commit.valid   = dec.valid;
        commit.pc      = dec.pc;
        commit.next_pc = next_pc;
        commit.rd_we   = wb_en && (dec.rd != '0);
        commit.rd      = dec.rd;
        commit.rd_data = wb_data;
    end

    assign redirect.next_pc = next_pc;

endmodule

//--- hw/rv_core.sv
// rv32i core top
// fetch, decode, register file and execute, one instruction every two cycles
`timescale 1ns/10ps

module rv_core #(
    parameter core_pkg::xlen_t RESET_PC = 32'h8000_0000
) (
    input  logic              clk,
    input  logic              reset,
    output core_pkg::xlen_t   imem_addr,
    input  core_pkg::xlen_t   imem_rdata,
    output core_pkg::commit_t commit
);
    import core_pkg::*;

    fetch_pkt_t fetch;
    decoded_t   dec;
    redirect_t  redirect;
    xlen_t      rdata1;
    xlen_t      rdata2;

    fetch_unit #(
        .RESET_PC(RESET_PC)
    ) fetch_i (
        .clk       (clk),
        .reset     (reset),
        .redirect  (redirect),
        .imem_addr (imem_addr),
        .imem_rdata(imem_rdata),
        .fetch     (fetch)
    );

    decode_unit decode_i (
        .fetch(fetch),
        .dec  (dec)
    );

    // writes land at the edge that ends the wait cycle
    reg_file regs_i (
        .clk   (clk),
        .reset (reset),
        .we    (commit.valid && commit.rd_we),
        .waddr (commit.rd),
        .wdata (commit.rd_data),
        .raddr1(dec.rs1),
        .raddr2(dec.rs2),
        .rdata1(rdata1),
        .rdata2(rdata2)
    );

    exec_unit exec_i (
        .dec     (dec),
        .rdata1  (rdata1),
        .rdata2  (rdata2),
        .commit  (commit),
        .redirect(redirect)
    );

endmodule

//--- tests/rv_core_chk.sv
// timing checks for the rv32i core
// commit spacing, reset behavior, x0 writes and fetch address hold
`timescale 1ns/10ps

module rv_core_chk (
    input logic              clk,
    input logic              reset,
    input core_pkg::xlen_t   imem_addr,
    input core_pkg::commit_t commit
);

    // one retirement per idle/wait pair
    valid_gap: assert property (@(posedge clk) disable iff (reset)
        commit.valid |=> !commit.valid)
        else $error("commit.valid high on two consecutive cycles");

    // covers the reset cycles and the idle cycle right after release
    quiet_after_reset: assert property (@(posedge clk) reset |=> !commit.valid)
        else $error("commit.valid high during reset or the cycle after it");

    no_x0_write: assert property (@(posedge clk) disable iff (reset)
        commit.rd_we |-> (commit.rd != 5'd0))
        else $error("rd_we asserted with rd zero");

    addr_held: assert property (@(posedge clk) disable iff (reset)
        commit.valid |-> $stable(imem_addr))  // wait cycle vs its idle cycle
        else $error("imem_addr changed between idle and wait");

endmodule

bind rv_core rv_core_chk chk_i (
    .clk      (clk),
    .reset    (reset),
    .imem_addr(imem_addr),
    .commit   (commit)
);

//--- tests/rv_core_tb.sv
// testbench for the rv32i core
// random program in a modelled instruction memory, checked against a reference model
`timescale 1ns/10ps

module rv_core_tb;
    import rv_isa_pkg::*;
    import core_pkg::*;

    localparam xlen_t RESET_PC    = 32'h8000_0000;
    localparam int    NUM_COMMITS = 2000;
    localparam int    CYCLE_LIMIT = 2 * NUM_COMMITS + 10 + 100;

    logic    clk = 1'b0;
    logic    reset;
    xlen_t   imem_addr;
    xlen_t   imem_rdata;
    commit_t commit;

    xlen_t       mem [256];
    logic [31:0] lfsr;
    int          cycles = 0;

    rv_core #(
        .RESET_PC(RESET_PC)
    ) dut_i (
        .clk       (clk),
        .reset     (reset),
        .imem_addr (imem_addr),
        .imem_rdata(imem_rdata),
        .commit    (commit)
    );

    always #2 clk = ~clk;

    // one-cycle memory, index wraps on address bits 9:2
    always @(posedge clk) begin
        imem_rdata <= mem[imem_addr[9:2]];
    end

    // taps 32, 22, 2, 1
    function automatic logic [31:0] lfsr_step(logic [31:0] s);
        return {s[30:0], s[31] ^ s[21] ^ s[1] ^ s[0]};
    endfunction

    task automatic take_bits(input int n, output logic [31:0] v);
        v = '0;
        for (int i = 0; i < n; i++) begin
            lfsr = lfsr_step(lfsr);
            v    = {v[30:0], lfsr[0]};
        end
    endtask

    task automatic build_program();
        logic [31:0] v;
        logic [31:0] rnd;
        logic [3:0]  cls;
        logic [4:0]  rd;
        logic [4:0]  rs1;
        logic [4:0]  rs2;
        logic [2:0]  f3;
        logic [6:0]  f7;
        logic [11:0] imm12;
        for (int i = 0; i < 256; i++) begin
            take_bits(4, v);
            cls = v[3:0];
            take_bits(5, v);
            rd = v[4:0];
            take_bits(5, v);
            rs1 = v[4:0];
            take_bits(5, v);
            rs2 = v[4:0];
            take_bits(3, v);
            f3 = v[2:0];
            take_bits(32, rnd);
            f7    = ((f3 == 3'd0 || f3 == 3'd5) && rnd[0]) ? 7'b0100000 : 7'b0000000;
            imm12 = rnd[11:0];
            if (f3 == 3'd1) imm12[11:5] = 7'b0000000;
            if (f3 == 3'd5) imm12[11:5] = {1'b0, rnd[12], 5'b00000};  // srli or srai
            case (cls)
                4'd4, 4'd5, 4'd6, 4'd15: mem[i] = {imm12, rs1, f3, rd, OPC_OP_IMM};
                4'd7:  mem[i] = {rnd[31:12], rd, OPC_LUI};
                4'd8:  mem[i] = {rnd[31:12], rd, OPC_AUIPC};
                4'd9, 4'd10: begin
                    if (f3[2:1] == 2'b01) f3[2] = 1'b1;  // only the six real conditions
                    mem[i] = {rnd[31:25], rs2, rs1, f3, rnd[11:7], OPC_BRANCH};
                end
                4'd11: mem[i] = {rnd[31:12], rd, OPC_JAL};
                4'd12: mem[i] = {rnd[31:20], rs1, 3'b000, rd, OPC_JALR};
                4'd13: mem[i] = {rnd[31:7], rnd[0] ? OPC_STORE : OPC_SYSTEM};
                default: mem[i] = {f7, rs2, rs1, f3, rd, OPC_OP};
            endcase
        end
    endtask

    function automatic xlen_t alu_result_of(logic [2:0] f3, logic alt, logic is_reg,
                                            xlen_t a, xlen_t b);
        case (f3)
            3'd0: return (is_reg && alt) ? a - b : a + b;
            3'd1: return a << b[4:0];
            3'd2: return {31'b0, $signed(a) < $signed(b)};
            3'd3: return {31'b0, a < b};
            3'd4: return a ^ b;
            3'd5: return alt ? xlen_t'($signed(a) >>> b[4:0]) : a >> b[4:0];
            3'd6: return a | b;
            default: return a & b;
        endcase
    endfunction

    function automatic logic branch_taken(logic [2:0] f3, xlen_t a, xlen_t b);
        case (f3)
            3'd0: return a == b;
            3'd1: return a != b;
            3'd4: return $signed(a) < $signed(b);
            3'd5: return $signed(a) >= $signed(b);
            3'd6: return a < b;
            3'd7: return a >= b;
            default: return 1'b0;
        endcase
    endfunction

    function automatic commit_t ref_step(xlen_t pc, xlen_t inst, xlen_t regs_in [32]);
        commit_t c;
        xlen_t   a;
        xlen_t   b;
        xlen_t   imm_i;
        xlen_t   imm_b;
        xlen_t   imm_u;
        xlen_t   imm_j;
        logic    wb;
        a         = regs_in[inst[19:15]];
        b         = regs_in[inst[24:20]];
        imm_i     = {{20{inst[31]}}, inst[31:20]};
        imm_b     = {{20{inst[31]}}, inst[7], inst[30:25], inst[11:8], 1'b0};
        imm_u     = {inst[31:12], 12'h000};
        imm_j     = {{12{inst[31]}}, inst[19:12], inst[20], inst[30:21], 1'b0};
        c         = '0;
        c.valid   = 1'b1;
        c.pc      = pc;
        c.next_pc = pc + 32'd4;
        c.rd      = inst[11:7];
        wb        = 1'b1;
        case (inst[6:0])
            OPC_OP:     c.rd_data = alu_result_of(inst[14:12], inst[30], 1'b1, a, b);
            OPC_OP_IMM: c.rd_data = alu_result_of(inst[14:12], inst[30], 1'b0, a, imm_i);
            OPC_LUI:    c.rd_data = imm_u;
            OPC_AUIPC:  c.rd_data = pc + imm_u;
            OPC_JAL: begin
                c.rd_data = pc + 32'd4;
                c.next_pc = pc + imm_j;
            end
            OPC_JALR: begin
                c.rd_data = pc + 32'd4;
                c.next_pc = (a + imm_i) & ~32'd1;
            end
            OPC_BRANCH: begin
                wb = 1'b0;
                if (branch_taken(inst[14:12], a, b)) c.next_pc = pc + imm_b;
            end
            default: wb = 1'b0;  // load, store, system and unknown words
        endcase
        c.rd_we = wb && (c.rd != 5'd0);
        return c;
    endfunction

    task automatic stop_on_error();
        $display("TEST RESULT: FAIL");
        $fatal(1, "simulation stopped at the first error");
    endtask

    task automatic check_pc(string what, xlen_t got, xlen_t exp);
        if (got !== exp) begin
            $display("MISMATCH at %0t ns: %s expected %h got %h", $time, what, exp, got);
            stop_on_error();
        end
    endtask

    task automatic verify_valid(string what, logic got, logic exp);
        if (got !== exp) begin
            $display("MISMATCH at %0t ns: %s expected %b got %b", $time, what, exp, got);
            stop_on_error();
        end
    endtask

    // rd and rd_data only matter when a write is expected
    task automatic check_wb(commit_t got, commit_t exp);
        if (got.rd_we !== exp.rd_we) begin
            $display("MISMATCH at %0t ns: rd_we at pc %h expected %b got %b",
                     $time, exp.pc, exp.rd_we, got.rd_we);
            stop_on_error();
        end else if (exp.rd_we && got.rd !== exp.rd) begin
            $display("MISMATCH at %0t ns: rd at pc %h expected %0d got %0d",
                     $time, exp.pc, exp.rd, got.rd);
            stop_on_error();
        end else if (exp.rd_we && got.rd_data !== exp.rd_data) begin
            $display("MISMATCH at %0t ns: rd_data at pc %h expected %h got %h",
                     $time, exp.pc, exp.rd_data, got.rd_data);
            stop_on_error();
        end
    endtask

    initial begin
        reset      <= 1'b1;
        imem_rdata <= '0;
        lfsr = 32'h814c00be;
        build_program();
        repeat (10) @(posedge clk);
        reset <= 1'b0;
        @(negedge clk);  // first idle cycle
        check_pc("imem_addr after reset", imem_addr, RESET_PC);
        verify_valid("commit.valid after reset", commit.valid, 1'b0);
    end

    initial begin : compare_proc
        xlen_t   model_regs [32];
        xlen_t   model_pc;
        commit_t exp;
        int      commits;
        for (int i = 0; i < 32; i++) begin
            model_regs[i] = '0;
        end
        model_pc = RESET_PC;
        commits  = 0;
        while (commits < NUM_COMMITS) begin
            @(negedge clk);
            if (!reset && commit.valid) begin
                exp = ref_step(model_pc, mem[model_pc[9:2]], model_regs);
                check_pc("pc", commit.pc, exp.pc);
                check_pc("next_pc", commit.next_pc, exp.next_pc);
                check_wb(commit, exp);
                if (exp.rd_we) model_regs[exp.rd] = exp.rd_data;
                model_pc = exp.next_pc;
                commits++;
            end
        end
        $display("TEST RESULT: PASS");
        $finish;
    end

    // stall watchdog
    initial begin
        while (cycles < CYCLE_LIMIT) begin
            @(posedge clk);
            cycles = cycles + 1;
        end
        $display("ERROR at %0t ns: the core stopped retiring instructions after %0d cycles",
                 $time, cycles);
        stop_on_error();
    end

endmodule

//--- project.f
hw/rv_isa_pkg.sv
hw/core_pkg.sv
hw/fetch_unit.sv
hw/decode_unit.sv
hw/reg_file.sv
hw/exec_unit.sv
hw/rv_core.sv
tests/rv_core_chk.sv
tests/rv_core_tb.sv

//--- Makefile
VERILATOR ?= verilator
VFLAGS    ?= --binary --timing --assert -j 0
TOP       ?= rv_core_tb
FILELIST  ?= project.f
OBJ_DIR   ?= obj_dir
LOG       ?= sim.log
PASS_MSG  := TEST RESULT: PASS

.PHONY: help test clean

help:
	@echo "targets:"
	@echo "  test   build with Verilator, run the testbench, check $(LOG)"
	@echo "  clean  remove the build directory and the log"
	@echo "  help   show this list"

test:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(OBJ_DIR) -f $(FILELIST)
	-./$(OBJ_DIR)/V$(TOP) > $(LOG) 2>&1
	@cat $(LOG)
	@grep -q "$(PASS_MSG)" $(LOG)

clean:
	rm -rf $(OBJ_DIR) $(LOG)
